// ==== dv/debug_cases.txt ====
# kind addr data expected, all hex
# both: SPI writes data to addr while DMI writes expected through sbdata0
dmi_wr 10 80010001 0
dmi_rd 10 0 80010001
dmi_wr 10 00000003 0
dmi_wr 10 00000001 0
dmi_wr 38 00000000 0
dmi_wr 39 00001000 0
dmi_wr 3c cafef00d 0
dmi_rd 38 0 00000000
dmi_wr 38 00100000 0
dmi_wr 39 00001000 0
dmi_rd 38 0 00100000
dmi_rd 3c 0 cafef00d
spi_wr 00002000 12345678 12345678
spi_rd 00002000 0 12345678
dmi_wr 38 00000000 0
dmi_wr 39 00003000 0
both 00004000 a5a5a5a5 0badc0de
spi_rd 00003000 0 0badc0de
spi_rd 00004000 0 a5a5a5a5
dmi_wr 3c 11111111 0
dmi_wr 3c 22222222 0
dmi_rd 38 0 00400000
dmi_wr 38 00400000 0
dmi_rd 38 0 00000000
spi_rd 00003000 0 11111111

// ==== tb.f ====
+incdir+include
logic/dbg_pkg.sv
logic/dm_core.sv
logic/spi_obi_bridge.sv
logic/obi_arbiter.sv
logic/obi_fifo.sv
logic/debug_subsystem.sv
dv/debug_subsystem_sva.sv
dv/tb_debug_subsystem.sv

// ==== Bender.yml ====
package:
  name: debug_subsystem

sources:
  - include_dirs:
      - include
    files:
      - logic/dbg_pkg.sv
      - logic/dm_core.sv
      - logic/spi_obi_bridge.sv
      - logic/obi_arbiter.sv
      - logic/obi_fifo.sv
      - logic/debug_subsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/debug_subsystem_sva.sv
      - dv/tb_debug_subsystem.sv

// ==== dv/tb_debug_subsystem.sv ====
// Testbench for the debug subsystem
// DMI and SPI drivers, OBI word memory model and checks against the cases file
`timescale 1ns/1ps
`default_nettype none
`include "dbg_cfg.svh"

module tb_debug_subsystem
  import dbg_pkg::*;
;

  localparam int SBCS_BUSY_BIT = 21;

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     dmi_req_valid_i;
  logic                     dmi_req_ready_o;
  dmi_req_t                 dmi_req_i;
  logic                     dmi_resp_valid_o;
  logic                     dmi_resp_ready_i;
  dmi_resp_t                dmi_resp_o;
  logic                     spi_sck_i;
  logic                     spi_cs_i;
  logic                     spi_mosi_i;
  logic                     spi_miso_o;
  logic                     debug_ndmreset_no;
  logic [`DBG_NR_HARTS-1:0] debug_core_req_o;
  obi_req_t                 debug_master_req_o;
  obi_resp_t                debug_master_resp_i;

  // Word memory behind the debug master port
  logic [31:0] mem [logic [31:0]];
  int unsigned access_count;
  int unsigned gnt_wait;
  int unsigned cycles;
  int unsigned cycle_limit;
  logic        sb_readonaddr;

  string       kinds [$];
  logic [31:0] addrs [$];
  logic [31:0] datas [$];
  logic [31:0] expects [$];

  debug_subsystem dut (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .dmi_req_valid_i     (dmi_req_valid_i),
    .dmi_req_ready_o     (dmi_req_ready_o),
    .dmi_req_i           (dmi_req_i),
    .dmi_resp_valid_o    (dmi_resp_valid_o),
    .dmi_resp_ready_i    (dmi_resp_ready_i),
    .dmi_resp_o          (dmi_resp_o),
    .spi_sck_i           (spi_sck_i),
    .spi_cs_i            (spi_cs_i),
    .spi_mosi_i          (spi_mosi_i),
    .spi_miso_o          (spi_miso_o),
    .debug_ndmreset_no   (debug_ndmreset_no),
    .debug_core_req_o    (debug_core_req_o),
    .debug_master_req_o  (debug_master_req_o),
    .debug_master_resp_i (debug_master_resp_i)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  // Unwritten words read back as the inverted address
  function automatic logic [31:0] mem_read(input logic [31:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return ~addr;
  endfunction

  // gnt after 0 to 3 idle cycles, rvalid one cycle after gnt
  always @(posedge clk_i) begin
    debug_master_resp_i.rvalid <= 1'b0;
    if (debug_master_req_o.req && debug_master_resp_i.gnt) begin
      check_value("debug_master_req_o.be", 32'(debug_master_req_o.be), 32'hF);
      access_count <= access_count + 1;
      debug_master_resp_i.gnt    <= 1'b0;
      debug_master_resp_i.rvalid <= 1'b1;
      debug_master_resp_i.rdata  <= mem_read(debug_master_req_o.addr);
      if (debug_master_req_o.we) begin
        mem[debug_master_req_o.addr] = debug_master_req_o.wdata;
      end
      gnt_wait <= $urandom % 4;
    end else if (debug_master_req_o.req) begin
      if (gnt_wait == 0) begin
        debug_master_resp_i.gnt <= 1'b1;
      end else begin
        gnt_wait <= gnt_wait - 1;
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic dmi_access(input dmi_op_e op, input logic [6:0] addr,
                            input logic [31:0] data, output logic [31:0] rdata);
    @(posedge clk_i);
    dmi_req_valid_i <= 1'b1;
    dmi_req_i       <= '{addr: addr, op: op, data: data};
    do begin
      @(negedge clk_i);
    end while (!dmi_req_ready_o);
    @(posedge clk_i);
    dmi_req_valid_i  <= 1'b0;
    dmi_resp_ready_i <= 1'b1;
    do begin
      @(negedge clk_i);
    end while (!dmi_resp_valid_o);
    rdata = dmi_resp_o.data;
    check_value("dmi_resp_o.resp", 32'(dmi_resp_o.resp), 32'h0);
    @(posedge clk_i);
    dmi_resp_ready_i <= 1'b0;
  endtask

  // Reads sbcs until the bus access is done, returns the final value
  task automatic sba_wait_idle(output logic [31:0] sbcs);
    do begin
      dmi_access(DMI_READ, `DBG_ADDR_SBCS, '0, sbcs);
    end while (sbcs[SBCS_BUSY_BIT]);
  endtask

  // One SCK period of 10 clk_i cycles, MISO sampled late in the low phase
  task automatic spi_bit(input logic b, output logic sampled);
    @(posedge clk_i);
    spi_sck_i  <= 1'b0;
    spi_mosi_i <= b;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    sampled = spi_miso_o;
    @(posedge clk_i);
    spi_sck_i <= 1'b1;
    repeat (4) @(posedge clk_i);
  endtask

  task automatic spi_frame(input logic is_write, input logic [31:0] addr,
                           input logic [31:0] data, output logic [31:0] rdata);
    logic [7:0] op;
    logic       s;
    op = is_write ? SPI_CMD_WRITE : SPI_CMD_READ;
    rdata = '0;
    @(posedge clk_i);
    spi_cs_i <= 1'b0;
    repeat (4) @(posedge clk_i);
    for (int i = 7; i >= 0; i--) begin
      spi_bit(op[i], s);
    end
    for (int i = 31; i >= 0; i--) begin
      spi_bit(addr[i], s);
    end
    if (is_write) begin
      for (int i = 31; i >= 0; i--) begin
        spi_bit(data[i], s);
      end
    end else begin
      repeat (8) spi_bit(1'b0, s);
      for (int i = 31; i >= 0; i--) begin
        spi_bit(1'b0, s);
        rdata[i] = s;
      end
    end
    @(posedge clk_i);
    spi_sck_i <= 1'b0;
    repeat (4) @(posedge clk_i);
    spi_cs_i <= 1'b1;
    repeat (8) @(posedge clk_i);
  endtask

  task automatic wait_accesses(input int unsigned target);
    while (access_count < target) begin
      @(negedge clk_i);
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          n;
    string       kind;
    string       rest;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    fd = $fopen("dv/debug_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the cases file dv/debug_cases.txt");
      $display("Simulation failed");
      $fatal(1, "missing stimulus");
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", kind);
      if (n != 1) begin
        break;
      end
      if (kind.substr(0, 0) == "#") begin
        n = $fgets(rest, fd);
      end else begin
        n = $fscanf(fd, "%h %h %h", a, d, e);
        kinds.push_back(kind);
        addrs.push_back(a);
        datas.push_back(d);
        expects.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  task automatic run_case(input string kind, input logic [31:0] a,
                          input logic [31:0] d, input logic [31:0] e);
    logic [31:0]              r;
    logic [31:0]              r2;
    logic [`DBG_NR_HARTS-1:0] exp_req;
    int unsigned              base;
    base = access_count;
    case (kind)
      "dmi_wr": begin
        dmi_access(DMI_WRITE, a[6:0], d, r);
        if (a[6:0] == `DBG_ADDR_SBCS) begin
          sb_readonaddr = d[20];
        end
        // Read on address issues exactly one bus read
        if (a[6:0] == `DBG_ADDR_SBADDRESS0 && sb_readonaddr) begin
          sba_wait_idle(r);
          check_value("bus access count", access_count, base + 1);
        end
        if (a[6:0] == `DBG_ADDR_DMCONTROL) begin
          exp_req = '0;
          if (d[0] && d[31]) begin
            exp_req[d[16 +: `DBG_HARTSEL_W]] = 1'b1;
          end
          @(negedge clk_i);
          check_value("debug_core_req_o", 32'(debug_core_req_o), 32'(exp_req));
          check_value("debug_ndmreset_no", 32'(debug_ndmreset_no), {31'b0, ~d[1]});
        end
      end
      "dmi_rd": begin
        if (a[6:0] == `DBG_ADDR_SBCS) begin
          sba_wait_idle(r);
        end else begin
          dmi_access(DMI_READ, a[6:0], '0, r);
        end
        check_value("dmi_resp_o.data", r, e);
      end
      "spi_wr": begin
        spi_frame(1'b1, a, d, r);
        wait_accesses(base + 1);
        @(negedge clk_i);
        check_value("mem word", mem_read(a), e);
        check_value("bus access count", access_count, base + 1);
      end
      "spi_rd": begin
        spi_frame(1'b0, a, '0, r);
        check_value("spi_miso_o word", r, e);
        check_value("bus access count", access_count, base + 1);
      end
      "both": begin
        // SPI writes d to a, DMI writes e through sbdata0
        fork
          spi_frame(1'b1, a, d, r);
          dmi_access(DMI_WRITE, `DBG_ADDR_SBDATA0, e, r2);
        join
        wait_accesses(base + 2);
        sba_wait_idle(r2);
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        check_value("mem word", mem_read(a), d);
        check_value("bus access count", access_count, base + 2);
      end
      default: begin
        $display("Unknown operation %s in the cases file", kind);
        $display("Simulation failed");
        $fatal(1, "bad stimulus");
      end
    endcase
  endtask

  initial begin
    void'($urandom(32'h71d1));
    clk_i               = 1'b0;
    rst_n_i             = 1'b0;
    dmi_req_valid_i     = 1'b0;
    dmi_req_i           = '0;
    dmi_resp_ready_i    = 1'b0;
    spi_sck_i           = 1'b0;
    spi_cs_i            = 1'b1;
    spi_mosi_i          = 1'b0;
    debug_master_resp_i = '0;
    access_count        = 0;
    gnt_wait            = 0;
    cycles              = 0;
    cycle_limit         = 0;
    sb_readonaddr       = 1'b0;
    load_cases();
    cycle_limit = 400 * (kinds.size() + 1);
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    for (int i = 0; i < kinds.size(); i++) begin
      run_case(kinds[i], addrs[i], datas[i], expects[i]);
    end
    repeat (5) @(posedge clk_i);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/debug_subsystem_sva.sv ====
// Handshake assertions for the debug subsystem
// DMI and OBI request stability, response bookkeeping, halt gating
`timescale 1ns/1ps
`default_nettype none
`include "dbg_cfg.svh"

module debug_subsystem_sva
  import dbg_pkg::*;
(
  input logic                     clk_i,
  input logic                     rst_n_i,
  input logic                     dmi_req_valid_i,
  input logic                     dmi_req_ready_o,
  input dmi_req_t                 dmi_req_i,
  input obi_req_t                 debug_master_req_o,
  input obi_resp_t                debug_master_resp_i,
  input logic [`DBG_NR_HARTS-1:0] debug_core_req_o,
  input logic                     dmactive_i
);

  int unsigned outstanding_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 0;
    end else begin
      outstanding_q <= outstanding_q
                     + ((debug_master_req_o.req && debug_master_resp_i.gnt) ? 1 : 0)
                     - (debug_master_resp_i.rvalid ? 1 : 0);
    end
  end

  a_dmi_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dmi_req_valid_i && !dmi_req_ready_o |=> dmi_req_valid_i && $stable(dmi_req_i))
    else $error("DMI request changed before it was accepted");

  a_obi_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    debug_master_req_o.req && !debug_master_resp_i.gnt
      |=> debug_master_req_o.req && $stable(debug_master_req_o))
    else $error("OBI request changed before gnt");

  a_rvalid_owned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    debug_master_resp_i.rvalid |-> outstanding_q != 0)
    else $error("rvalid without an outstanding access");

  a_halt_gated: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !dmactive_i |-> debug_core_req_o == '0)
    else $error("halt request while the debug module is inactive");

endmodule

bind debug_subsystem debug_subsystem_sva sva (
  .clk_i               (clk_i),
  .rst_n_i             (rst_n_i),
  .dmi_req_valid_i     (dmi_req_valid_i),
  .dmi_req_ready_o     (dmi_req_ready_o),
  .dmi_req_i           (dmi_req_i),
  .debug_master_req_o  (debug_master_req_o),
  .debug_master_resp_i (debug_master_resp_i),
  .debug_core_req_o    (debug_core_req_o),
  .dmactive_i          (i_dm_core.dmactive_q)
);

`default_nettype wire

// ==== logic/debug_subsystem.sv ====
// Debug subsystem top level
// DMI debug module and SPI bridge sharing one OBI master port
`timescale 1ns/1ps
`default_nettype none
`include "dbg_cfg.svh"

module debug_subsystem
  import dbg_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     dmi_req_valid_i,
  output logic                     dmi_req_ready_o,
  input  dmi_req_t                 dmi_req_i,
  output logic                     dmi_resp_valid_o,
  input  logic                     dmi_resp_ready_i,
  output dmi_resp_t                dmi_resp_o,
  input  logic                     spi_sck_i,
  input  logic                     spi_cs_i,
  input  logic                     spi_mosi_i,
  output logic                     spi_miso_o,
  output logic                     debug_ndmreset_no,
  output logic [`DBG_NR_HARTS-1:0] debug_core_req_o,
  output obi_req_t                 debug_master_req_o,
  input  obi_resp_t                debug_master_resp_i
);

  logic      ndmreset;
  obi_req_t  arb_req [2];
  obi_resp_t arb_resp [2];
  obi_req_t  fifo_req;
  obi_resp_t fifo_resp;

  assign debug_ndmreset_no = ~ndmreset;

  dm_core i_dm_core (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .dmi_req_valid_i  (dmi_req_valid_i),
    .dmi_req_ready_o  (dmi_req_ready_o),
    .dmi_req_i        (dmi_req_i),
    .dmi_resp_valid_o (dmi_resp_valid_o),
    .dmi_resp_ready_i (dmi_resp_ready_i),
    .dmi_resp_o       (dmi_resp_o),
    .debug_req_o      (debug_core_req_o),
    .ndmreset_o       (ndmreset),
    .sba_req_o        (arb_req[0]),
    .sba_resp_i       (arb_resp[0])
  );

  spi_obi_bridge i_spi_obi_bridge (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .spi_sck_i  (spi_sck_i),
    .spi_cs_i   (spi_cs_i),
    .spi_mosi_i (spi_mosi_i),
    .spi_miso_o (spi_miso_o),
    .obi_req_o  (arb_req[1]),
    .obi_resp_i (arb_resp[1])
  );

  obi_arbiter i_obi_arbiter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .mst_req_i  (arb_req),
    .mst_resp_o (arb_resp),
    .slv_req_o  (fifo_req),
    .slv_resp_i (fifo_resp)
  );

  obi_fifo i_obi_fifo (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .producer_req_i  (fifo_req),
    .producer_resp_o (fifo_resp),
    .consumer_req_o  (debug_master_req_o),
    .consumer_resp_i (debug_master_resp_i)
  );

endmodule

`default_nettype wire

// ==== logic/obi_fifo.sv ====
// OBI request FIFO
// Circular buffer on the request path, responses pass straight through
`timescale 1ns/1ps
`default_nettype none
`include "dbg_cfg.svh"

module obi_fifo
  import dbg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  obi_req_t  producer_req_i,
  output obi_resp_t producer_resp_o,
  output obi_req_t  consumer_req_o,
  input  obi_resp_t consumer_resp_i
);

  localparam int unsigned DEPTH = `DBG_OBI_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  obi_req_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  assign full  = (count_q == (PTR_W+1)'(DEPTH));
  assign empty = (count_q == '0);
  assign push  = producer_req_i.req & ~full;
  assign pop   = ~empty & consumer_resp_i.gnt;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= producer_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
  end

  always_comb begin
    consumer_req_o         = mem_q[rd_ptr_q];
    consumer_req_o.req     = ~empty;
    producer_resp_o.gnt    = push;
    producer_resp_o.rvalid = consumer_resp_i.rvalid;
    producer_resp_o.rdata  = consumer_resp_i.rdata;
  end

endmodule

`default_nettype wire

// ==== logic/obi_arbiter.sv ====
// Two-to-one round-robin OBI arbiter
// One access in flight, response routed back to its owner
`timescale 1ns/1ps
`default_nettype none

module obi_arbiter
  import dbg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  obi_req_t  mst_req_i [2],
  output obi_resp_t mst_resp_o [2],
  output obi_req_t  slv_req_o,
  input  obi_resp_t slv_resp_i
);

  logic busy_q;
  logic wait_q;
  logic owner_q;
  logic last_q;
  logic pick;
  logic sel;

  // Tie goes to the master not granted last
  assign pick = (mst_req_i[0].req & mst_req_i[1].req) ? ~last_q : mst_req_i[1].req;
  // Keep the choice stable while a request waits for gnt
  assign sel  = wait_q ? owner_q : pick;

  always_comb begin
    slv_req_o     = mst_req_i[sel];
    slv_req_o.req = mst_req_i[sel].req & ~busy_q;
  end

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      mst_resp_o[i] = '0;
    end
    mst_resp_o[sel].gnt        = slv_req_o.req & slv_resp_i.gnt;
    mst_resp_o[owner_q].rvalid = busy_q & slv_resp_i.rvalid;
    mst_resp_o[owner_q].rdata  = slv_resp_i.rdata;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      wait_q  <= 1'b0;
      owner_q <= 1'b0;
      last_q  <= 1'b1;
    end else begin
      if (slv_req_o.req && slv_resp_i.gnt) begin
        busy_q  <= 1'b1;
        wait_q  <= 1'b0;
        owner_q <= sel;
        last_q  <= sel;
      end else if (slv_req_o.req) begin
        wait_q  <= 1'b1;
        owner_q <= sel;
      end
      if (busy_q && slv_resp_i.rvalid) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/spi_obi_bridge.sv ====
// SPI target to OBI bridge
// Decodes word read and write frames into single bus accesses
`timescale 1ns/1ps
`default_nettype none

module spi_obi_bridge
  import dbg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      spi_sck_i,
  input  logic      spi_cs_i,
  input  logic      spi_mosi_i,
  output logic      spi_miso_o,
  output obi_req_t  obi_req_o,
  input  obi_resp_t obi_resp_i
);

  logic [2:0]  sck_sync_q;
  logic [1:0]  cs_sync_q;
  logic [1:0]  mosi_sync_q;
  logic        sck_rise;
  logic        sck_fall;
  logic        cs_active;
  spi_state_e  state_q;
  logic [4:0]  cnt_q;
  logic [31:0] shift_q;
  logic [31:0] shift_in;
  logic        frame_wr_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic        req_q;
  logic        we_q;
  logic [31:0] tx_q;
  logic        miso_q;

  // Two stages into clk_i, third stage for edge detection
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sck_sync_q  <= '0;
      cs_sync_q   <= 2'b11;
      mosi_sync_q <= '0;
    end else begin
      sck_sync_q  <= {sck_sync_q[1:0], spi_sck_i};
      cs_sync_q   <= {cs_sync_q[0], spi_cs_i};
      mosi_sync_q <= {mosi_sync_q[0], spi_mosi_i};
    end
  end

  assign sck_rise  = sck_sync_q[1] & ~sck_sync_q[2];
  assign sck_fall  = ~sck_sync_q[1] & sck_sync_q[2];
  assign cs_active = ~cs_sync_q[1];
  assign shift_in  = {shift_q[30:0], mosi_sync_q[1]};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= SPI_CMD;
      cnt_q      <= '0;
      shift_q    <= '0;
      frame_wr_q <= 1'b0;
      addr_q     <= '0;
      wdata_q    <= '0;
      req_q      <= 1'b0;
      we_q       <= 1'b0;
    end else begin
      if (obi_resp_i.gnt) begin
        req_q <= 1'b0;
      end
      if (!cs_active) begin
        state_q <= SPI_CMD;
        cnt_q   <= '0;
      end else if (sck_rise) begin
        shift_q <= shift_in;
        cnt_q   <= cnt_q + 5'd1;
        case (state_q)
          SPI_CMD: begin
            if (cnt_q == 5'd7) begin
              cnt_q      <= '0;
              frame_wr_q <= (shift_in[7:0] == SPI_CMD_WRITE);
              if (shift_in[7:0] == SPI_CMD_WRITE || shift_in[7:0] == SPI_CMD_READ) begin
                state_q <= SPI_ADDR;
              end else begin
                state_q <= SPI_DONE;
              end
            end
          end
          SPI_ADDR: begin
            if (cnt_q == 5'd31) begin
              cnt_q  <= '0;
              addr_q <= shift_in;
              if (frame_wr_q) begin
                state_q <= SPI_WDATA;
              end else begin
                req_q   <= 1'b1;
                we_q    <= 1'b0;
                state_q <= SPI_DUMMY;
              end
            end
          end
          SPI_WDATA: begin
            if (cnt_q == 5'd31) begin
              wdata_q <= shift_in;
              req_q   <= 1'b1;
              we_q    <= 1'b1;
              state_q <= SPI_DONE;
            end
          end
          SPI_DUMMY: begin
            if (cnt_q == 5'd7) begin
              cnt_q   <= '0;
              state_q <= SPI_RDATA;
            end
          end
          SPI_RDATA: begin
            if (cnt_q == 5'd31) begin
              state_q <= SPI_DONE;
            end
          end
          default: state_q <= SPI_DONE;
        endcase
      end
    end
  end

  // Read data shifts out on falling edges
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_q   <= '0;
      miso_q <= 1'b0;
    end else begin
      if (obi_resp_i.rvalid) begin
        tx_q <= obi_resp_i.rdata;
      end
      if (!cs_active) begin
        miso_q <= 1'b0;
      end else if (sck_fall) begin
        if (state_q == SPI_RDATA) begin
          miso_q <= tx_q[31];
          tx_q   <= {tx_q[30:0], 1'b0};
        end else begin
          miso_q <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    obi_req_o.req   = req_q;
    obi_req_o.we    = we_q;
    obi_req_o.be    = 4'hF;
    obi_req_o.addr  = addr_q;
    obi_req_o.wdata = wdata_q;
  end

  assign spi_miso_o = miso_q;

endmodule

`default_nettype wire

// ==== logic/dm_core.sv ====
// Debug module core
// DMI register file, halt and reset control, system bus access master
`timescale 1ns/1ps
`default_nettype none
`include "dbg_cfg.svh"

module dm_core
  import dbg_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     dmi_req_valid_i,
  output logic                     dmi_req_ready_o,
  input  dmi_req_t                 dmi_req_i,
  output logic                     dmi_resp_valid_o,
  input  logic                     dmi_resp_ready_i,
  output dmi_resp_t                dmi_resp_o,
  output logic [`DBG_NR_HARTS-1:0] debug_req_o,
  output logic                     ndmreset_o,
  output obi_req_t                 sba_req_o,
  input  obi_resp_t                sba_resp_i
);

  logic                      ready_en_q;
  logic                      resp_valid_q;
  logic [31:0]               resp_data_q;
  logic                      dmactive_q;
  logic                      ndmreset_q;
  logic                      haltreq_q;
  logic [`DBG_HARTSEL_W-1:0] hartsel_q;
  logic                      sbreadonaddr_q;
  logic                      sbbusyerror_q;
  logic [31:0]               sbaddr_q;
  logic [31:0]               sbdata_q;
  logic                      sb_we_q;
  sba_state_e                sba_state_q;
  logic                      sbbusy;
  logic                      dmi_accept;
  logic                      dmi_wr;
  logic                      sb_access;
  logic                      start_rd;
  logic                      start_wr;
  logic [31:0]               dmcontrol_rd;
  logic [31:0]               sbcs_rd;
  logic [31:0]               rd_data;

  assign dmi_accept = dmi_req_valid_i & dmi_req_ready_o;
  assign dmi_wr     = dmi_accept & (dmi_req_i.op == DMI_WRITE);
  assign sbbusy     = (sba_state_q != SBA_IDLE);
  assign sb_access  = dmi_accept & (dmi_req_i.op != DMI_NOP) &
                      ((dmi_req_i.addr == `DBG_ADDR_SBADDRESS0) ||
                       (dmi_req_i.addr == `DBG_ADDR_SBDATA0));
  assign start_wr   = dmi_wr & ~sbbusy & (dmi_req_i.addr == `DBG_ADDR_SBDATA0);
  assign start_rd   = dmi_wr & ~sbbusy & sbreadonaddr_q &
                      (dmi_req_i.addr == `DBG_ADDR_SBADDRESS0);

  always_comb begin
    dmcontrol_rd = '0;
    dmcontrol_rd[0] = dmactive_q;
    dmcontrol_rd[1] = ndmreset_q;
    dmcontrol_rd[16 +: `DBG_HARTSEL_W] = hartsel_q;
    dmcontrol_rd[31] = haltreq_q;
    sbcs_rd = '0;
    sbcs_rd[20] = sbreadonaddr_q;
    sbcs_rd[21] = sbbusy;
    sbcs_rd[22] = sbbusyerror_q;
    case (dmi_req_i.addr)
      `DBG_ADDR_DMCONTROL:  rd_data = dmcontrol_rd;
      `DBG_ADDR_SBCS:       rd_data = sbcs_rd;
      `DBG_ADDR_SBADDRESS0: rd_data = sbaddr_q;
      `DBG_ADDR_SBDATA0:    rd_data = sbdata_q;
      default:              rd_data = '0;
    endcase
  end

  // One response per request, held until taken
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_en_q   <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      ready_en_q <= 1'b1;
      if (dmi_accept) begin
        resp_valid_q <= 1'b1;
      end else if (dmi_resp_ready_i) begin
        resp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (dmi_accept) begin
      resp_data_q <= (dmi_req_i.op == DMI_READ) ? rd_data : '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dmactive_q <= 1'b0;
      ndmreset_q <= 1'b0;
      haltreq_q  <= 1'b0;
      hartsel_q  <= '0;
    end else if (dmi_wr && dmi_req_i.addr == `DBG_ADDR_DMCONTROL) begin
      dmactive_q <= dmi_req_i.data[0];
      ndmreset_q <= dmi_req_i.data[1];
      hartsel_q  <= dmi_req_i.data[16 +: `DBG_HARTSEL_W];
      haltreq_q  <= dmi_req_i.data[31];
    end
  end

  // System bus access registers and FSM
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sbreadonaddr_q <= 1'b0;
      sbbusyerror_q  <= 1'b0;
      sbaddr_q       <= '0;
      sbdata_q       <= '0;
      sb_we_q        <= 1'b0;
      sba_state_q    <= SBA_IDLE;
    end else begin
      if (dmi_wr && dmi_req_i.addr == `DBG_ADDR_SBCS) begin
        sbreadonaddr_q <= dmi_req_i.data[20];
        if (dmi_req_i.data[22]) begin
          sbbusyerror_q <= 1'b0;
        end
      end
      if (sb_access && sbbusy) begin
        sbbusyerror_q <= 1'b1;
      end
      if (dmi_wr && !sbbusy && dmi_req_i.addr == `DBG_ADDR_SBADDRESS0) begin
        sbaddr_q <= dmi_req_i.data;
      end
      if (start_wr) begin
        sbdata_q <= dmi_req_i.data;
      end
      case (sba_state_q)
        SBA_IDLE: begin
          if (start_rd || start_wr) begin
            sb_we_q     <= start_wr;
            sba_state_q <= SBA_REQ;
          end
        end
        SBA_REQ: begin
          if (sba_resp_i.gnt) begin
            sba_state_q <= SBA_WAIT;
          end
        end
        SBA_WAIT: begin
          if (sba_resp_i.rvalid) begin
            if (!sb_we_q) begin
              sbdata_q <= sba_resp_i.rdata;
            end
            sba_state_q <= SBA_IDLE;
          end
        end
        default: sba_state_q <= SBA_IDLE;
      endcase
    end
  end

  always_comb begin
    sba_req_o.req   = (sba_state_q == SBA_REQ);
    sba_req_o.we    = sb_we_q;
    sba_req_o.be    = 4'hF;
    sba_req_o.addr  = sbaddr_q;
    sba_req_o.wdata = sbdata_q;
  end

  always_comb begin
    for (int i = 0; i < `DBG_NR_HARTS; i++) begin
      debug_req_o[i] = dmactive_q & haltreq_q & (hartsel_q == `DBG_HARTSEL_W'(i));
    end
  end

  assign ndmreset_o       = ndmreset_q;
  assign dmi_req_ready_o  = ready_en_q & ~resp_valid_q;
  assign dmi_resp_valid_o = resp_valid_q;
  assign dmi_resp_o.data  = resp_data_q;
  assign dmi_resp_o.resp  = 2'b00;

endmodule

`default_nettype wire

// ==== logic/dbg_pkg.sv ====
// Debug subsystem types
// DMI and OBI channel structs plus the FSM state and opcode enums
`default_nettype none

package dbg_pkg;

  typedef enum logic [1:0] {
    DMI_NOP   = 2'd0,
    DMI_READ  = 2'd1,
    DMI_WRITE = 2'd2
  } dmi_op_e;

  typedef struct packed {
    logic [6:0]  addr;
    dmi_op_e     op;
    logic [31:0] data;
  } dmi_req_t;

  // resp is always 0 (success)
  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } dmi_resp_t;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef enum logic [1:0] {
    SBA_IDLE,
    SBA_REQ,
    SBA_WAIT
  } sba_state_e;

  typedef enum logic [2:0] {
    SPI_CMD,
    SPI_ADDR,
    SPI_WDATA,
    SPI_DUMMY,
    SPI_RDATA,
    SPI_DONE
  } spi_state_e;

  typedef enum logic [7:0] {
    SPI_CMD_WRITE = 8'h02,
    SPI_CMD_READ  = 8'h0B
  } spi_cmd_e;

endpackage

`default_nettype wire

// ==== include/dbg_cfg.svh ====
// Debug subsystem configuration
// Hart count, DMI register map and bus buffer depth
`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

// Harts under debug control
`define DBG_NR_HARTS 2
`define DBG_HARTSEL_W 1

// DMI register addresses
`define DBG_ADDR_DMCONTROL 7'h10
`define DBG_ADDR_SBCS 7'h38
`define DBG_ADDR_SBADDRESS0 7'h39
`define DBG_ADDR_SBDATA0 7'h3C

// Entries in the OBI request FIFO
`define DBG_OBI_FIFO_DEPTH 2

`endif
